/* logic/divPkg.sv */
`default_nettype none

package divPkg;

	// ========================================================================
	// Widths and sizes
	// ========================================================================

	// Operand and result width of one machine word
	localparam int dataWidth = 64;
	// Width of the tag that follows an operation through the unit
	localparam int tagWidth = 4;
	// Entries in the request queue between operand stage and divider
	localparam int fifoDepth = 4;

	// Divide modes where the fourth encoding is never issued
	typedef enum logic [1:0] {
		modeUnsigned = 2'd0,
		modeSigned = 2'd1,
		modeSignedUnsigned = 2'd2
	} divModeT;

	// ========================================================================
	// Stream payloads
	// ========================================================================

	// Operation as presented by the issue port
	typedef struct packed {
		divModeT mode;
		logic useImm;
		logic [dataWidth-1:0] dividend;
		logic [dataWidth-1:0] divisor;
		logic [dataWidth-1:0] imm;
		logic [tagWidth-1:0] tag;
	} divIssueT;

	// Request after operand preparation, magnitudes only
	typedef struct packed {
		logic [dataWidth-1:0] dividendMag;
		logic [dataWidth-1:0] divisorMag;
		logic quotNeg;
		logic remNeg;
		logic divByZero;
		// Raw dividend is kept for the zero-divisor remainder
		logic [dataWidth-1:0] dividendRaw;
		logic [tagWidth-1:0] tag;
	} divRequestT;

	// Final result handed back to the execute stage
	typedef struct packed {
		logic [dataWidth-1:0] quotient;
		logic [dataWidth-1:0] remainder;
		logic divByZero;
		logic [tagWidth-1:0] tag;
	} divResultT;

endpackage

`default_nettype wire

/* logic/divOperandPrep.sv */
`timescale 1ns/1ps
`default_nettype none

module divOperandPrep (
	input wire logic clk,
	input wire logic rst,
	input wire logic abort,
	input wire logic issueValid,
	output logic issueReady,
	input divPkg::divIssueT issue,
	output logic reqValid,
	input wire logic reqReady,
	output divPkg::divRequestT req
);

	import divPkg::*;

	// Divisor after the immediate select
	logic [dataWidth-1:0] divisorSel;
	// Operand signs as seen under the current mode
	logic dividendNeg;
	logic divisorNeg;
	// Request built from the issue port this cycle
	divRequestT nextReq;

	// ========================================================================
	// Operand preparation
	// ========================================================================

	always_comb begin
		divisorSel = issue.useImm ? issue.imm : issue.divisor;
		// The dividend counts as signed in both signed modes
		dividendNeg = (issue.mode != modeUnsigned) && issue.dividend[dataWidth-1];
		// Only the fully signed mode treats the divisor as signed
		divisorNeg = (issue.mode == modeSigned) && divisorSel[dataWidth-1];

		// Two's-complement magnitudes where the most negative value maps onto itself
		nextReq.dividendMag = dividendNeg ? -issue.dividend : issue.dividend;
		nextReq.divisorMag = divisorNeg ? -divisorSel : divisorSel;
		// Quotient is negative when the signs differ
		nextReq.quotNeg = dividendNeg ^ divisorNeg;
		// Remainder follows the dividend
		nextReq.remNeg = dividendNeg;
		nextReq.divByZero = (divisorSel == '0);
		nextReq.dividendRaw = issue.dividend;
		nextReq.tag = issue.tag;
	end

	// ========================================================================
	// Output register
	// ========================================================================

	// Accept while the register is empty or drains in this same cycle
	assign issueReady = !reqValid || reqReady;

	// Output valid sets on an accepted issue and clears on reset and abort
	always_ff @(posedge clk) begin
		if (rst) begin
			reqValid <= 1'b0;
		end else if (abort) begin
			reqValid <= 1'b0;
		end else if (issueValid && issueReady) begin
			reqValid <= 1'b1;
		end else if (reqReady) begin
			reqValid <= 1'b0;
		end
	end

	// Payload register only loads on an accepted issue
	always_ff @(posedge clk) begin
		if (issueValid && issueReady) begin
			req <= nextReq;
		end
	end

	// ========================================================================
	// Assertions
	// ========================================================================

	// The execute stage never issues the spare mode encoding
	assert property (@(posedge clk) disable iff (rst)
		issueValid |-> (issue.mode inside {modeUnsigned, modeSigned, modeSignedUnsigned}))
		else $error("divOperandPrep: unused divide mode issued");

endmodule

`default_nettype wire

/* logic/divRequestFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module divRequestFifo #(
	parameter type payloadT = logic
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic flush,
	input wire logic inValid,
	output logic inReady,
	input payloadT inData,
	output logic outValid,
	input wire logic outReady,
	output payloadT outData
);

	import divPkg::*;

	// Pointer and occupancy types sized from the queue depth
	typedef logic [$clog2(fifoDepth)-1:0] ptrT;
	typedef logic [$clog2(fifoDepth+1)-1:0] countT;

	// Circular storage where the count tells which entries hold data
	payloadT mem [fifoDepth];
	ptrT wrPtr;
	ptrT rdPtr;
	countT count;
	logic push;
	logic pop;

	// ========================================================================
	// Handshake
	// ========================================================================

	// Only a full queue pushes back on the operand stage
	assign inReady = (count != countT'(fifoDepth));
	assign outValid = (count != '0);
	// Oldest entry is always presented at the read pointer
	assign outData = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	// ========================================================================
	// Pointers and count
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap explicitly so any depth works
			if (push) begin
				wrPtr <= (wrPtr == ptrT'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrT'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the count unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Write side of the storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	// ========================================================================
	// Assertions
	// ========================================================================

	// Occupancy stays within the storage at all times
	assert property (@(posedge clk) disable iff (rst)
		count <= countT'(fifoDepth))
		else $error("divRequestFifo: count above depth");

	// Pointer distance and count agree whenever the queue is neither empty nor full
	assert property (@(posedge clk) disable iff (rst)
		(count != '0) && (count != countT'(fifoDepth)) |-> (wrPtr != rdPtr))
		else $error("divRequestFifo: pointers disagree with count");

endmodule

`default_nettype wire

/* logic/divIterCore.sv */
`timescale 1ns/1ps
`default_nettype none

module divIterCore (
	input wire logic clk,
	input wire logic rst,
	input wire logic abort,
	input wire logic reqValid,
	output logic reqReady,
	input divPkg::divRequestT req,
	output logic resultValid,
	input wire logic resultReady,
	output divPkg::divResultT result
);

	import divPkg::*;

	typedef enum logic [1:0] {
		stIdle,
		stDivide,
		stDone
	} stateT;

	// Counter must reach dataWidth, so it needs one bit beyond the log
	typedef logic [$clog2(dataWidth+1)-1:0] bitCountT;

	stateT state;
	bitCountT bitCount;

	// Request being worked on, kept for signs, divisor and tag
	divRequestT held;
	// Dividend shifts out at the top while quotient bits enter at the bottom
	logic [dataWidth-1:0] quot;
	// Partial remainder, one bit wider than the data
	logic [dataWidth:0] partRem;
	divResultT resultReg;

	logic accept;
	logic step;
	logic finish;
	logic [dataWidth:0] shifted;
	logic [dataWidth:0] trial;
	logic fits;

	// ========================================================================
	// Handshake and step control
	// ========================================================================

	assign reqReady = (state == stIdle);
	assign resultValid = (state == stDone);
	assign result = resultReg;

	assign accept = reqValid && reqReady;
	// One quotient bit per cycle while bits remain
	assign step = (state == stDivide) && (bitCount != '0);
	// Extra cycle after the last bit for the sign fix-up
	assign finish = (state == stDivide) && (bitCount == '0);

	// Restoring step: bring down the next dividend bit and try the subtract
	assign shifted = {partRem[dataWidth-1:0], quot[dataWidth-1]};
	assign fits = (shifted >= {1'b0, held.divisorMag});
	assign trial = shifted - {1'b0, held.divisorMag};

	// ========================================================================
	// State machine
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			bitCount <= '0;
		end else if (abort) begin
			// Abort drops the division in flight and any result on display
			state <= stIdle;
			bitCount <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (accept) begin
						bitCount <= bitCountT'(dataWidth);
						state <= stDivide;
					end
				end
				stDivide: begin
					if (step) begin
						bitCount <= bitCount - 1'b1;
					end else begin
						state <= stDone;
					end
				end
				stDone: begin
					// Result is held until the execute stage takes it
					if (resultReady) begin
						state <= stIdle;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// ========================================================================
	// Datapath
	// ========================================================================

	always_ff @(posedge clk) begin
		if (accept) begin
			held <= req;
			quot <= req.dividendMag;
			partRem <= '0;
		end
		if (step) begin
			quot <= {quot[dataWidth-2:0], fits};
			partRem <= fits ? trial : shifted;
		end
		if (finish) begin
			if (held.divByZero) begin
				// Zero divisor gives all ones and hands back the raw dividend
				resultReg.quotient <= '1;
				resultReg.remainder <= held.dividendRaw;
			end else begin
				resultReg.quotient <= held.quotNeg ? -quot : quot;
				resultReg.remainder <= held.remNeg ? -partRem[dataWidth-1:0]
					: partRem[dataWidth-1:0];
			end
			resultReg.divByZero <= held.divByZero;
			resultReg.tag <= held.tag;
		end
	end

	// ========================================================================
	// Assertions
	// ========================================================================

	// A stalled result must not change under the consumer
	assert property (@(posedge clk) disable iff (rst || abort)
		resultValid && !resultReady |=> resultValid && $stable(result))
		else $error("divIterCore: result changed while stalled");

	// Result turns valid dataWidth+1 cycles after the accepting edge and is first sampled one edge later
	assert property (@(posedge clk) disable iff (rst || abort)
		accept |-> ##(dataWidth + 2) $rose(resultValid))
		else $error("divIterCore: result latency differs from dataWidth+1");

endmodule

`default_nettype wire

/* logic/divUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module divUnit (
	input wire logic clk,
	input wire logic rst,
	input wire logic abort,
	input wire logic issueValid,
	output logic issueReady,
	input divPkg::divIssueT issue,
	output logic resultValid,
	input wire logic resultReady,
	output divPkg::divResultT result
);

	import divPkg::*;

	// Prepared request from the operand stage into the queue
	logic reqValid;
	logic reqReady;
	divRequestT req;

	// Queued request from the queue into the divider
	logic qValid;
	logic qReady;
	divRequestT qReq;

	// ========================================================================
	// Operand stage
	// ========================================================================

	divOperandPrep operandPrep_i (
		.clk(clk),
		.rst(rst),
		.abort(abort),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.issue(issue),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req)
	);

	// Queue lets issue run ahead of the long divide
	divRequestFifo #(
		.payloadT(divRequestT)
	) requestFifo_i (
		.clk(clk),
		.rst(rst),
		.flush(abort),
		.inValid(reqValid),
		.inReady(reqReady),
		.inData(req),
		.outValid(qValid),
		.outReady(qReady),
		.outData(qReq)
	);

	// ========================================================================
	// Divider
	// ========================================================================

	divIterCore iterCore_i (
		.clk(clk),
		.rst(rst),
		.abort(abort),
		.reqValid(qValid),
		.reqReady(qReady),
		.req(qReq),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result)
	);

endmodule

`default_nettype wire

/* verification/divUnitTbTasks.svh */
`ifndef DIV_UNIT_TB_TASKS_SVH
`define DIV_UNIT_TB_TASKS_SVH

// ============================================================================
// Stimulus helpers
// ============================================================================

function automatic logic [dataWidth-1:0] randomWord();
	return {$random(seed), $random(seed)};
endfunction

// The unused divisor source gets the inverse value so a wrong select shows up
function automatic divIssueT makeOp(input divModeT mode, input logic useImm,
	input logic [dataWidth-1:0] dividend, input logic [dataWidth-1:0] divisor);
	divIssueT op;
	op.mode = mode;
	op.useImm = useImm;
	op.dividend = dividend;
	op.divisor = useImm ? ~divisor : divisor;
	op.imm = useImm ? divisor : ~divisor;
	op.tag = nextTag;
	nextTag = nextTag + 1'b1;
	return op;
endfunction

// Called right after a rising edge and returns right after the transfer edge
task automatic issueOp(input divIssueT op);
	issue <= op;
	issueValid <= 1'b1;
	@(negedge clk);
	while (!issueReady) begin
		stallCount++;
		@(negedge clk);
	end
	@(posedge clk);
	expectQ.push_back(expectResult(op));
endtask

task automatic waitDrain();
	int cycles;
	cycles = 0;
	while (expectQ.size() != 0 && cycles < drainLimit) begin
		@(negedge clk);
		cycles++;
	end
	if (expectQ.size() != 0) begin
		errors++;
		$display("%0d issued operations never returned a result", expectQ.size());
		expectQ.delete();
	end
	@(posedge clk);
endtask

// ============================================================================
// Directed tests
// ============================================================================

task automatic testResetAbort();
	int i;
	@(negedge clk);
	if (resultValid !== 1'b0) begin
		errors++;
		$display("CHECK FAILED resultValid after reset: expected %h actual %h", 1'b0, resultValid);
	end
	if (issueReady !== 1'b1) begin
		errors++;
		$display("CHECK FAILED issueReady after reset: expected %h actual %h", 1'b1, issueReady);
	end
	@(posedge clk);
	// Core, queue and prep register each hold one operation when abort hits
	for (i = 0; i < 3; i++) begin
		issueOp(makeOp(modeUnsigned, i[0], randomWord(), randomWord() | 64'd1));
	end
	issueValid <= 1'b0;
	abort <= 1'b1;
	expectQ.delete();
	@(posedge clk);
	abort <= 1'b0;
	issueOp(makeOp(modeSigned, 1'b0, -64'd100, 64'd7));
	issueValid <= 1'b0;
	waitDrain();
endtask

task automatic testUnsigned();
	int i;
	@(posedge clk);
	issueOp(makeOp(modeUnsigned, 1'b0, 64'd100, 64'd7));
	issueOp(makeOp(modeUnsigned, 1'b1, 64'd100, 64'd7));
	issueOp(makeOp(modeUnsigned, 1'b0, '1, 64'd1));
	issueOp(makeOp(modeUnsigned, 1'b1, '1, 64'd3));
	issueOp(makeOp(modeUnsigned, 1'b0, 64'd5, 64'd100));
	issueOp(makeOp(modeUnsigned, 1'b1, minNeg, minNeg | 64'd1));
	// Shifting the divisor spreads the quotient over many sizes
	for (i = 0; i < 12; i++) begin
		issueOp(makeOp(modeUnsigned, i[0], randomWord(), randomWord() >> (5 * i)));
	end
	issueValid <= 1'b0;
	waitDrain();
endtask

task automatic testSigned();
	int k;
	int s;
	divModeT mode;
	logic [dataWidth-1:0] dvd;
	logic [dataWidth-1:0] dvs;
	@(posedge clk);
	for (k = 0; k < 2; k++) begin
		mode = (k == 0) ? modeSigned : modeSignedUnsigned;
		// Bit 1 of s negates the dividend and bit 0 the divisor
		for (s = 0; s < 4; s++) begin
			dvd = s[1] ? -64'd7 : 64'd7;
			dvs = s[0] ? -64'd2 : 64'd2;
			issueOp(makeOp(mode, s[0], dvd, dvs));
			dvd = s[1] ? -(randomWord() >> 2) : (randomWord() >> 2);
			dvs = s[0] ? -(randomWord() >> 40) : (randomWord() >> 40);
			issueOp(makeOp(mode, s[1], dvd, dvs));
		end
		issueOp(makeOp(mode, 1'b0, minNeg, '1));
		issueOp(makeOp(mode, 1'b1, minNeg, 64'd1));
	end
	issueValid <= 1'b0;
	waitDrain();
endtask

task automatic testZeroDivisor();
	int m;
	divModeT mode;
	@(posedge clk);
	for (m = 0; m < 3; m++) begin
		mode = divModeT'(m[1:0]);
		issueOp(makeOp(mode, 1'b0, -64'd5, '0));
		issueOp(makeOp(mode, 1'b1, randomWord(), '0));
		issueOp(makeOp(mode, 1'b0, minNeg, '0));
	end
	issueValid <= 1'b0;
	waitDrain();
endtask

task automatic testBackPressure();
	int i;
	divModeT mode;
	@(posedge clk);
	stallCount = 0;
	randomReady = 1'b1;
	// Eight operations overfill the six places in the unit
	for (i = 0; i < 8; i++) begin
		mode = divModeT'(2'(i % 3));
		issueOp(makeOp(mode, i[0], randomWord(), randomWord() >> (8 * i)));
	end
	issueValid <= 1'b0;
	waitDrain();
	randomReady = 1'b0;
	if (stallCount == 0) begin
		errors++;
		$display("issueReady never dropped while the unit was full");
	end
endtask

`endif

/* verification/divUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module divUnitTb;

	import divPkg::*;

	// Watchdog budget of 200 tests at one divide plus some slack each
	localparam int testCount = 200;
	localparam int watchdogCycles = testCount * (dataWidth + 10);
	// Longest wait for a full unit to drain under random back-pressure
	localparam int drainLimit = 8 * (fifoDepth + 2) * (dataWidth + 10);
	localparam logic [dataWidth-1:0] minNeg = {1'b1, {(dataWidth-1){1'b0}}};

	logic clk;
	logic rst;
	logic abort;
	logic issueValid;
	logic issueReady;
	divIssueT issue;
	logic resultValid;
	logic resultReady;
	divResultT result;

	// Operand stimulus and the ready toggling draw from separate seeds
	integer seed;
	integer readySeed;
	logic randomReady;
	logic [tagWidth-1:0] nextTag;
	int errors;
	int resultsSeen;
	int stallCount;

	// Expected results in issue order, each carrying its tag
	divResultT expectQ[$];
	divResultT expected;
	divResultT heldResult;
	logic holding;

	divUnit divUnit_i (
		.clk(clk),
		.rst(rst),
		.abort(abort),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.issue(issue),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result(result)
	);

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic divResultT expectResult(input divIssueT op);
		logic [dataWidth-1:0] divisorSel;
		logic signed [dataWidth:0] a;
		logic signed [dataWidth:0] b;
		logic signed [dataWidth:0] q;
		logic signed [dataWidth:0] r;
		divResultT want;
		divisorSel = op.useImm ? op.imm : op.divisor;
		// One extra bit lets all three modes share a single signed division
		a = (op.mode == modeUnsigned) ? {1'b0, op.dividend}
			: {op.dividend[dataWidth-1], op.dividend};
		b = (op.mode == modeSigned) ? {divisorSel[dataWidth-1], divisorSel}
			: {1'b0, divisorSel};
		want.tag = op.tag;
		want.divByZero = (divisorSel == '0);
		if (want.divByZero) begin
			want.quotient = '1;
			want.remainder = op.dividend;
		end else begin
			// Signed / truncates toward zero and % follows the dividend sign
			q = a / b;
			r = a % b;
			want.quotient = q[dataWidth-1:0];
			want.remainder = r[dataWidth-1:0];
		end
		return want;
	endfunction

	`include "divUnitTbTasks.svh"

	// ========================================================================
	// Clock, ready driver and result monitor
	// ========================================================================

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		logic [31:0] rnd;
		readySeed = 32'hcdce;
		resultReady = 1'b0;
		forever begin
			@(posedge clk);
			rnd = $random(readySeed);
			resultReady <= randomReady ? rnd[0] : 1'b1;
		end
	end

	// Sampled on the falling edge where every DUT output has settled
	always @(negedge clk) begin
		if (rst || abort) begin
			holding = 1'b0;
		end else if (resultValid) begin
			if (holding && result !== heldResult) begin
				errors++;
				$display("CHECK FAILED result held: expected %h actual %h", heldResult, result);
			end
			if (resultReady) begin
				holding = 1'b0;
				resultsSeen++;
				if (expectQ.size() == 0) begin
					errors++;
					$display("A result with tag %h arrived that was never issued", result.tag);
				end else begin
					expected = expectQ.pop_front();
					if (result.tag !== expected.tag) begin
						errors++;
						$display("CHECK FAILED tag: expected %h actual %h", expected.tag, result.tag);
					end
					if (result.quotient !== expected.quotient) begin
						errors++;
						$display("CHECK FAILED quotient tag %h: expected %h actual %h",
							expected.tag, expected.quotient, result.quotient);
					end
					if (result.remainder !== expected.remainder) begin
						errors++;
						$display("CHECK FAILED remainder tag %h: expected %h actual %h",
							expected.tag, expected.remainder, result.remainder);
					end
					if (result.divByZero !== expected.divByZero) begin
						errors++;
						$display("CHECK FAILED divByZero tag %h: expected %h actual %h",
							expected.tag, expected.divByZero, result.divByZero);
					end
				end
			end else begin
				holding = 1'b1;
				heldResult = result;
			end
		end else if (holding) begin
			errors++;
			$display("resultValid dropped before the held result was taken");
			holding = 1'b0;
		end
	end

	// ========================================================================
	// Watchdog and test sequence
	// ========================================================================

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("The watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		seed = 32'hcdce;
		errors = 0;
		resultsSeen = 0;
		stallCount = 0;
		nextTag = '0;
		randomReady = 1'b0;
		holding = 1'b0;
		rst = 1'b1;
		abort = 1'b0;
		issueValid = 1'b0;
		issue = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		testResetAbort();
		testUnsigned();
		testSigned();
		testZeroDivisor();
		testBackPressure();
		// A few idle cycles catch any stray result
		repeat (10) @(posedge clk);
		$display("errors: %0d, results checked: %0d", errors, resultsSeen);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verification
logic/divPkg.sv
logic/divOperandPrep.sv
logic/divRequestFifo.sv
logic/divIterCore.sv
logic/divUnit.sv
verification/divUnitTb.sv

/* Makefile */
TOP := divUnitTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the divUnit testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
